// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mycpu_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
source/cpu_pkg.sv
source/exec_ctrl_if.sv
source/regfile.sv
source/alu.sv
source/fetch_control.sv
source/inst_decoder.sv
source/execute_writeback.sv
source/mycpu_top.sv
verif/mycpu_checker.sv
verif/mycpu_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   alu_src1,
    input  cpu_pkg::word_t   alu_src2,
    output cpu_pkg::word_t   alu_result
);
    import cpu_pkg::*;

    logic        invert_b;
    word_t       adder_b;
    logic [32:0] adder_sum;
    logic        slt_bit, sltu_bit;
    logic [4:0]  shamt;

    // Subtraction and both compares reuse the adder as a + ~b + 1.
    assign invert_b  = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b   = invert_b ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, invert_b};

    assign slt_bit  = (alu_src1[31] & ~alu_src2[31])
                    | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31]);
    assign sltu_bit = ~adder_sum[32];   // No carry out means a borrow.
    assign shamt    = alu_src2[4:0];

    assign alu_result =
        ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum[31:0])
      | ({32{alu_op[ALU_SLT]}}  & {31'd0, slt_bit})
      | ({32{alu_op[ALU_SLTU]}} & {31'd0, sltu_bit})
      | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
      | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
      | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
      | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
      | ({32{alu_op[ALU_SLL]}}  & (alu_src1 << shamt))
      | ({32{alu_op[ALU_SRL]}}  & (alu_src1 >> shamt))
      | ({32{alu_op[ALU_SRA]}}  & word_t'($signed(alu_src1) >>> shamt))
      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;   // One-hot with the bit positions below.

    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EXE = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } cpu_state_t;

    localparam reg_addr_t LINK_REG = 5'd1;   // Destination of bl.

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // Three-register and shift-immediate forms are matched on inst[31:15].
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;   // inst[31:22]
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    localparam logic [5:0]  OP_JIRL   = 6'h13;     // inst[31:26]
    localparam logic [5:0]  OP_B      = 6'h14;
    localparam logic [5:0]  OP_BL     = 6'h15;
    localparam logic [5:0]  OP_BEQ    = 6'h16;
    localparam logic [5:0]  OP_BNE    = 6'h17;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;    // inst[31:25]

endpackage

// ==== source/exec_ctrl_if.sv ====
`timescale 1ns/1ns

interface exec_ctrl_if;
    import cpu_pkg::*;

    alu_op_t   alu_op;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     store_data;
    reg_addr_t dest;
    logic      gr_we;
    logic      mem_we;
    logic      res_from_mem;

    modport decode (
        output alu_op, alu_src1, alu_src2, store_data,
        output dest, gr_we, mem_we, res_from_mem
    );

    modport execute (
        input alu_op, alu_src1, alu_src2, store_data,
        input dest, gr_we, mem_we, res_from_mem
    );

endinterface

// ==== source/execute_writeback.sv ====
`timescale 1ns/1ns

module execute_writeback (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::word_t      pc,
    exec_ctrl_if.execute        ctrl,
    output logic                data_sram_we,
    output cpu_pkg::word_t      data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata,
    input  cpu_pkg::word_t      data_sram_rdata,
    output logic                rf_we,
    output cpu_pkg::reg_addr_t  rf_waddr,
    output cpu_pkg::word_t      rf_wdata,
    output cpu_pkg::word_t      debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output cpu_pkg::reg_addr_t  debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);
    import cpu_pkg::*;

    word_t alu_result;
    word_t alu_result_q;
    word_t mem_data_q;
    word_t retire_pc;

    alu u_alu (
        .alu_op     (ctrl.alu_op),
        .alu_src1   (ctrl.alu_src1),
        .alu_src2   (ctrl.alu_src2),
        .alu_result (alu_result)
    );

    // The fetch pc moves on at the end of ID, so its value is captured there.
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_pc <= 32'd0;
        end else if (state == ID) begin
            retire_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXE) begin
            alu_result_q <= alu_result;
        end
        if (state == MEM) begin
            mem_data_q <= data_sram_rdata;
        end
    end

    assign data_sram_we    = (state == MEM) & ctrl.mem_we;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = ctrl.store_data;

    assign rf_we    = (state == WB) & ctrl.gr_we;
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = ctrl.res_from_mem ? mem_data_q : alu_result_q;

    assign debug_wb_pc       = retire_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== source/fetch_control.sv ====
`timescale 1ns/1ns

module fetch_control #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    input  logic               br_taken,
    input  cpu_pkg::word_t     br_target,
    input  logic               ends_at_id,
    input  logic               mem_access,
    input  logic               mem_load,
    output cpu_pkg::cpu_state_t state,
    output cpu_pkg::word_t     pc,
    output cpu_pkg::word_t     inst
);
    import cpu_pkg::*;

    cpu_state_t next_state;
    logic       mem_access_q;   // Instruction class kept for EXE and MEM.
    logic       mem_load_q;

    assign inst_sram_addr = pc;

    always_comb begin
        next_state = IF;
        case (state)
            IF: begin
                next_state = ID;
            end
            ID: begin
                next_state = ends_at_id ? IF : EXE;   // Plain branches finish here.
            end
            EXE: begin
                next_state = mem_access_q ? MEM : WB;
            end
            MEM: begin
                next_state = mem_load_q ? WB : IF;
            end
            WB: begin
                next_state = IF;
            end
            default: begin
                next_state = IF;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IF;
            pc           <= RESET_PC;
            mem_access_q <= 1'b0;
            mem_load_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ID) begin
                pc           <= br_taken ? br_target : pc + 32'd4;
                mem_access_q <= mem_access;
                mem_load_q   <= mem_load;
            end
        end
    end

    // Holds the fetched word for decode in ID.
    always_ff @(posedge clk) begin
        if (state == IF) begin
            inst <= inst_sram_rdata;
        end
    end

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::word_t      pc,
    input  cpu_pkg::word_t      inst,
    exec_ctrl_if.decode         ctrl,
    output logic                br_taken,
    output cpu_pkg::word_t      br_target,
    output logic                ends_at_id,
    output logic                mem_access,
    output logic                mem_load,
    input  logic                rf_we,
    input  cpu_pkg::reg_addr_t  rf_waddr,
    input  cpu_pkg::word_t      rf_wdata
);
    import cpu_pkg::*;

    reg_addr_t rd, rj, rk;
    logic      inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic      inst_nor, inst_and, inst_or, inst_xor;
    logic      inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic      inst_ld_w, inst_st_w, inst_jirl, inst_b;
    logic      inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic      need_ui5, need_si20, need_si26, src2_is_4, src2_is_imm;
    word_t     ui5, si12, si20, offs16, offs26, imm;
    reg_addr_t rf_raddr2;
    word_t     rj_value, rkd_value;
    alu_op_t   alu_op;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign inst_add_w   = inst[31:15] == OP_ADD_W;
    assign inst_sub_w   = inst[31:15] == OP_SUB_W;
    assign inst_slt     = inst[31:15] == OP_SLT;
    assign inst_sltu    = inst[31:15] == OP_SLTU;
    assign inst_nor     = inst[31:15] == OP_NOR;
    assign inst_and     = inst[31:15] == OP_AND;
    assign inst_or      = inst[31:15] == OP_OR;
    assign inst_xor     = inst[31:15] == OP_XOR;
    assign inst_slli_w  = inst[31:15] == OP_SLLI_W;
    assign inst_srli_w  = inst[31:15] == OP_SRLI_W;
    assign inst_srai_w  = inst[31:15] == OP_SRAI_W;
    assign inst_addi_w  = inst[31:22] == OP_ADDI_W;
    assign inst_ld_w    = inst[31:22] == OP_LD_W;
    assign inst_st_w    = inst[31:22] == OP_ST_W;
    assign inst_jirl    = inst[31:26] == OP_JIRL;
    assign inst_b       = inst[31:26] == OP_B;
    assign inst_bl      = inst[31:26] == OP_BL;
    assign inst_beq     = inst[31:26] == OP_BEQ;
    assign inst_bne     = inst[31:26] == OP_BNE;
    assign inst_lu12i_w = inst[31:25] == OP_LU12I_W;

    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl;   // Address and link sums.
    assign alu_op[ALU_SUB]  = inst_sub_w;
    assign alu_op[ALU_SLT]  = inst_slt;
    assign alu_op[ALU_SLTU] = inst_sltu;
    assign alu_op[ALU_AND]  = inst_and;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or;
    assign alu_op[ALU_XOR]  = inst_xor;
    assign alu_op[ALU_SLL]  = inst_slli_w;
    assign alu_op[ALU_SRL]  = inst_srli_w;
    assign alu_op[ALU_SRA]  = inst_srai_w;
    assign alu_op[ALU_LUI]  = inst_lu12i_w;

    assign need_ui5    = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20   = inst_lu12i_w;
    assign need_si26   = inst_b | inst_bl;
    assign src2_is_4   = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | need_si20 | src2_is_4;

    assign ui5    = {27'd0, inst[14:10]};
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'd0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? si20  :
                 need_ui5  ? ui5   : si12;

    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    assign br_taken   = (inst_beq & (rj_value == rkd_value))
                      | (inst_bne & (rj_value != rkd_value))
                      | inst_jirl | inst_bl | inst_b;
    assign br_target  = inst_jirl ? rj_value + offs16 :
                        pc + (need_si26 ? offs26 : offs16);
    assign ends_at_id = inst_b | inst_beq | inst_bne;
    assign mem_access = inst_ld_w | inst_st_w;
    assign mem_load   = inst_ld_w;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.gr_we        <= 1'b0;
            ctrl.mem_we       <= 1'b0;
            ctrl.res_from_mem <= 1'b0;
        end else if (state == ID) begin
            ctrl.gr_we        <= ~(inst_st_w | inst_beq | inst_bne | inst_b);
            ctrl.mem_we       <= inst_st_w;
            ctrl.res_from_mem <= inst_ld_w;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ID) begin
            ctrl.alu_op     <= alu_op;
            ctrl.alu_src1   <= src2_is_4 ? pc : rj_value;   // Link value is pc + 4.
            ctrl.alu_src2   <= src2_is_imm ? imm : rkd_value;
            ctrl.store_data <= rkd_value;
            ctrl.dest       <= inst_bl ? LINK_REG : rd;
        end
    end

endmodule

// ==== source/mycpu_top.sv ====
`timescale 1ns/1ns

module mycpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    cpu_state_t state;
    word_t      pc;
    word_t      inst;
    logic       br_taken;
    word_t      br_target;
    logic       ends_at_id;
    logic       mem_access;
    logic       mem_load;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;

    exec_ctrl_if ctrl_bus ();

    fetch_control #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .ends_at_id      (ends_at_id),
        .mem_access      (mem_access),
        .mem_load        (mem_load),
        .state           (state),
        .pc              (pc),
        .inst            (inst)
    );

    inst_decoder u_decode (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .pc         (pc),
        .inst       (inst),
        .ctrl       (ctrl_bus.decode),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .ends_at_id (ends_at_id),
        .mem_access (mem_access),
        .mem_load   (mem_load),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata)
    );

    execute_writeback u_exec_wb (
        .clk               (clk),
        .reset             (reset),
        .state             (state),
        .pc                (pc),
        .ctrl              (ctrl_bus.execute),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    output cpu_pkg::word_t     rdata1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [31:1];   // There is no storage behind r0.

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== verif/mycpu_checker.sv ====
`timescale 1ns/1ns

module mycpu_checker (
    input logic       clk,
    input logic       reset,
    input logic       data_sram_we,
    input logic [3:0] debug_wb_rf_we
);

    trace_we_whole: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we == 4'h0) || (debug_wb_rf_we == 4'hf))
        else $error("Trace write enable has a mix of set and clear bits.");

    store_not_with_write: assert property (@(posedge clk) disable iff (reset)
        !(data_sram_we && (debug_wb_rf_we != 4'h0)))
        else $error("Store and register write were active in the same cycle.");

    store_single_cycle: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else $error("Data memory write enable stayed high for two cycles.");

    // Also covers the first cycle once reset is released.
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!data_sram_we && (debug_wb_rf_we == 4'h0)))
        else $error("A write enable was high right after reset.");

endmodule

bind mycpu_top mycpu_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);

// ==== verif/mycpu_tb.sv ====
`timescale 1ns/1ns

module mycpu_tb;

    localparam logic [31:0] RESET_PC       = 32'h1c00_0000;
    localparam int          PROG_WORDS     = 300;
    localparam int          LAST           = PROG_WORDS - 1;
    localparam logic [31:0] END_PC         = RESET_PC + 32'(LAST * 4);
    localparam int          TIMEOUT_CYCLES = 2000;

    typedef enum int {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_NOR, K_AND, K_OR, K_XOR, K_SLLI, K_SRLI,
        K_SRAI, K_ADDI, K_LD, K_ST, K_JIRL, K_B, K_BL, K_BEQ, K_BNE, K_LU12I
    } op_kind_t;

    typedef enum int {
        EV_NONE, EV_WRITE, EV_STORE
    } event_t;

    // Opcode bits of each kind, in the order of op_kind_t.
    localparam logic [31:0] OP_BASE [20] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000,
        32'h0014_0000, 32'h0014_8000, 32'h0015_0000, 32'h0015_8000,
        32'h0040_8000, 32'h0044_8000, 32'h0048_8000, 32'h0280_0000,
        32'h2880_0000, 32'h2980_0000, 32'h4c00_0000, 32'h5000_0000,
        32'h5400_0000, 32'h5800_0000, 32'h5c00_0000, 32'h1400_0000
    };

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    int          seed;
    logic [31:0] imem [PROG_WORDS];
    op_kind_t    op_kind [PROG_WORDS];
    logic [4:0]  op_rd [PROG_WORDS];
    logic [4:0]  op_rj [PROG_WORDS];
    logic [4:0]  op_rk [PROG_WORDS];   // Shift amount for the shift-immediate forms.
    int          op_imm [PROG_WORDS];
    logic [31:0] dmem [512];

    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [512];
    event_t      ev_kind;
    logic [31:0] ev_pc;
    logic [4:0]  ev_num;
    logic [31:0] ev_data;
    logic [31:0] ev_addr;
    int          writes;
    int          stores;

    always #50 clk = ~clk;

    mycpu_top #(
        .RESET_PC (RESET_PC)
    ) mycpu_top_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return (32'(idx) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        if (offset < 32'(PROG_WORDS * 4)) begin
            return imem[offset[10:2]];
        end
        return 32'h0;   // Outside the program reads as zero.
    endfunction

    function automatic logic [31:0] encode(op_kind_t kind, logic [4:0] rd, logic [4:0] rj,
                                           logic [4:0] rk, int imm);
        logic [31:0] reg_fields;
        reg_fields = {22'd0, rj, rd};
        case (kind)
            K_ADDI, K_LD, K_ST:
                return OP_BASE[kind] | {10'd0, imm[11:0], 10'd0} | reg_fields;
            K_JIRL, K_BEQ, K_BNE:
                return OP_BASE[kind] | {6'd0, imm[15:0], 10'd0} | reg_fields;
            K_B, K_BL:
                return OP_BASE[kind] | {6'd0, imm[15:0], 10'd0} | {22'd0, imm[25:16]};
            K_LU12I:
                return OP_BASE[kind] | {7'd0, imm[19:0], 5'd0} | {27'd0, rd};
            default:
                return OP_BASE[kind] | {17'd0, rk, 10'd0} | reg_fields;
        endcase
    endfunction

    task automatic place_inst(int idx, op_kind_t kind, logic [4:0] rd, logic [4:0] rj,
                              logic [4:0] rk, int imm);
        op_kind[idx] = kind;
        op_rd[idx]   = rd;
        op_rj[idx]   = rj;
        op_rk[idx]   = rk;
        op_imm[idx]  = imm;
        imem[idx]    = encode(kind, rd, rj, rk, imm);
    endtask

    task automatic build_program();
        op_kind_t   kind;
        logic [4:0] rd;
        logic [4:0] rj;
        int         imm;
        int         span;
        for (int i = 0; i < 31; i++) begin   // Preamble gives every register a value.
            rd  = 5'(i + 1);
            imm = (rd == 5'd30) ? 0 : (rd == 5'd31) ? 32'h1c000 : rand_below(1 << 20);
            place_inst(i, K_LU12I, rd, 5'd0, 5'd0, imm);
        end
        for (int i = 31; i < LAST; i++) begin
            kind = op_kind_t'(rand_below(20));
            rd   = 5'(rand_below(30));   // r30 and r31 keep their base values.
            rj   = 5'(rand_below(32));
            span = (LAST - i > 8) ? 8 : LAST - i;
            imm  = 0;
            case (kind)
                K_ADDI:  imm = rand_below(4096) - 2048;
                K_LD, K_ST: begin
                    rj  = 5'd30;
                    imm = 4 * (rand_below(2) == 1 ? rand_below(512) : rand_below(16));
                end
                K_JIRL: begin
                    rj  = 5'd31;
                    imm = i + 1 + rand_below(span);
                end
                K_B, K_BL, K_BEQ, K_BNE: imm = 1 + rand_below(span);
                K_LU12I: imm = rand_below(1 << 20);
                default: imm = 0;
            endcase
            place_inst(i, kind, rd, rj, 5'(rand_below(32)), imm);
        end
        place_inst(LAST, K_B, 5'd0, 5'd0, 5'd0, 0);   // Final self-loop.
    endtask

    // Executes one instruction of the reference model.
    task automatic step_model();
        int          idx;
        op_kind_t    kind;
        logic [31:0] src_j;
        logic [31:0] src_k;
        logic [31:0] src_d;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] npc;
        idx     = int'((model_pc - RESET_PC) >> 2);
        kind    = op_kind[idx];
        src_j   = model_regs[op_rj[idx]];
        src_k   = model_regs[op_rk[idx]];
        src_d   = model_regs[op_rd[idx]];
        imm     = 32'(op_imm[idx]);
        npc     = model_pc + 32'd4;
        res     = model_pc + 32'd4;   // Link value of bl and jirl.
        ev_kind = EV_WRITE;
        ev_pc   = model_pc;
        ev_num  = (kind == K_BL) ? 5'd1 : op_rd[idx];
        case (kind)
            K_ADD:   res = src_j + src_k;
            K_SUB:   res = src_j - src_k;
            K_SLT:   res = {31'd0, $signed(src_j) < $signed(src_k)};
            K_SLTU:  res = {31'd0, src_j < src_k};
            K_NOR:   res = ~(src_j | src_k);
            K_AND:   res = src_j & src_k;
            K_OR:    res = src_j | src_k;
            K_XOR:   res = src_j ^ src_k;
            K_SLLI:  res = src_j << op_rk[idx];
            K_SRLI:  res = src_j >> op_rk[idx];
            K_SRAI:  res = $signed(src_j) >>> op_rk[idx];
            K_ADDI:  res = src_j + imm;
            K_LD: begin
                ev_addr = src_j + imm;
                res     = model_mem[ev_addr[10:2]];
            end
            K_ST: begin
                ev_kind = EV_STORE;
                ev_addr = src_j + imm;
                ev_data = src_d;
                model_mem[ev_addr[10:2]] = src_d;
            end
            K_JIRL:  npc = src_j + (imm << 2);
            K_BL:    npc = model_pc + (imm << 2);
            K_B: begin
                ev_kind = EV_NONE;
                npc     = model_pc + (imm << 2);
            end
            K_BEQ, K_BNE: begin
                ev_kind = EV_NONE;
                if ((src_j == src_d) == (kind == K_BEQ)) begin
                    npc = model_pc + (imm << 2);
                end
            end
            default: res = imm << 12;   // lu12i.w
        endcase
        if (ev_kind == EV_WRITE) begin
            ev_data = res;
            if (ev_num != 5'd0) begin
                model_regs[ev_num] = res;
            end
        end
        model_pc = npc;
    endtask

    task automatic next_event();
        int steps;
        ev_kind = EV_NONE;
        steps   = 0;
        while (ev_kind == EV_NONE && model_pc != END_PC) begin
            step_model();
            steps++;
            if (steps > PROG_WORDS) begin
                fail_run("The reference model ran too long without a write or a store.");
            end
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else fail_run($sformatf("MISMATCH %s: expected %08h, actual %08h",
                                    name, expected, actual));
    endtask

    task automatic check_write();
        next_event();
        assert (ev_kind == EV_WRITE)
            else fail_run($sformatf("The DUT wrote r%0d at pc %08h but the model does not.",
                                    debug_wb_rf_wnum, debug_wb_pc));
        check_value("trace pc", ev_pc, debug_wb_pc);
        check_value("trace register", {27'd0, ev_num}, {27'd0, debug_wb_rf_wnum});
        check_value("trace data", ev_data, debug_wb_rf_wdata);
        writes++;
    endtask

    task automatic check_store();
        next_event();
        assert (ev_kind == EV_STORE)
            else fail_run($sformatf("The DUT stored to %08h but the model does not store.",
                                    data_sram_addr));
        check_value("store address", ev_addr, data_sram_addr);
        check_value("store data", ev_data, data_sram_wdata);
        stores++;
    endtask

    // Both memories answer from the address seen at the falling edge.
    always @(negedge clk) begin
        if (reset) begin
            for (int k = 0; k < 512; k++) begin
                dmem[k] <= fill_word(k);
            end
        end else if (data_sram_we) begin
            dmem[data_sram_addr[10:2]] <= data_sram_wdata;
        end
        inst_sram_rdata <= fetch_word(inst_sram_addr);
        data_sram_rdata <= dmem[data_sram_addr[10:2]];
    end

    initial begin
        int cycles;
        int idle;
        seed = 32'hdb51_c500;
        build_program();
        for (int i = 0; i < 512; i++) begin
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        model_pc = RESET_PC;
        writes   = 0;
        stores   = 0;

        repeat (16) begin
            @(negedge clk);
            assert (debug_wb_rf_we == 4'h0 && !data_sram_we)
                else fail_run("A write enable was high while reset was held.");
        end
        reset = 1'b0;
        @(negedge clk);
        assert (debug_wb_rf_we == 4'h0 && !data_sram_we)
            else fail_run("A write enable was high in the first cycle after reset.");
        check_value("reset fetch address", RESET_PC, inst_sram_addr);

        cycles = 0;
        idle   = 0;
        while (idle < 8) begin   // Only the final self-loop keeps the pc there this long.
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_run("Timeout: the program did not reach its final loop in 2000 cycles.");
            end
            if (debug_wb_rf_we != 4'h0) begin
                check_write();
            end
            if (data_sram_we) begin
                check_store();
            end
            idle = (inst_sram_addr == END_PC) ? idle + 1 : 0;
        end

        next_event();
        if (ev_kind == EV_NONE && model_pc == END_PC) begin
            $display("Matched %0d register writes and %0d stores in %0d cycles.",
                     writes, stores, cycles);
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("The DUT reached the final loop before making all of the model's writes.");
        end
    end

endmodule
